//--- Bender.yml
package:
  name: mem_stream_slave

sources:
  - include_dirs:
      - common
    files:
      - common/mem_pkg.sv
      - common/mem_dec_if.sv
      - design/mem_decode.sv
      - ram/ram_bank.sv
      - stream/stream_ports.sv
      - design/bus_response.sv
      - design/irq_timer.sv
      - design/mem_top.sv

  - target: test
    include_dirs:
      - common
    files:
      - verif/tb_mem_top.sv

//--- common/mem_dec_if.sv
`timescale 1ns/100ps

`include "mem_macros.svh"

interface mem_dec_if;
  import mem_pkg::*;

  logic access;                          // Valid and not yet answered
  logic first;                           // First cycle of a new valid
  region_e region;                       // RAM, TX or RX
  port_idx_t port;                       // Stream port for TX/RX
  logic [`RAM_ADDR_BITS-1:0] ram_index;  // Word index into RAM
  strb_t wstrb;                          // Byte write strobes
  word_t wdata;                          // Write data

  modport dec (
    output access, first, region, port, ram_index, wstrb, wdata
  );

  modport ram (
    input access, region, ram_index, wstrb, wdata
  );

  modport strm (
    input first, region, port
  );

  modport rsp (
    input access, region, port
  );

endinterface

//--- common/mem_macros.svh
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// Core bus geometry
`define MEM_DATA_W 32
`define MEM_LANES 4

// Word index into the data RAM
`define RAM_ADDR_BITS 10

// Stream port count and the upper address field of their window
`define NUM_STREAMS 5
`define MMIO_BASE 26'h040_0000

// Timer width and the low slice used for the fast interrupt
`define IRQ_CNT_W 16
`define IRQ_FAST_BITS 13

`endif

//--- common/mem_pkg.sv
`include "mem_macros.svh"

package mem_pkg;

  typedef logic [`MEM_DATA_W-1:0] word_t;  // One bus data word
  typedef logic [`MEM_LANES-1:0] strb_t;   // One bit per byte lane
  typedef logic [2:0] port_idx_t;          // Stream port number 0..4

  // Access class picked by the decoder
  typedef enum logic [1:0] {
    REG_RAM,
    REG_TX,
    REG_RX
  } region_e;

  // One address seen as a RAM word pointer or as a stream register
  typedef union packed {
    struct packed {
      logic [`MEM_DATA_W-`RAM_ADDR_BITS-3:0] tag;  // Ignored, RAM is aliased
      logic [`RAM_ADDR_BITS-1:0] index;            // Word index
      logic [1:0] offset;                          // Byte within word
    } ram;
    struct packed {
      logic [25:0] base;    // Must equal MMIO_BASE
      logic [3:0] reg_idx;  // Odd for RX, even for TX
      logic [1:0] offset;   // Byte within word
    } mmio;
  } mem_addr_u;

endpackage

//--- design/bus_response.sv
`timescale 1ns/100ps

`include "mem_macros.svh"

module bus_response (
  input  logic                               clk,
  input  logic                               resetn,
  mem_dec_if.rsp                             rsp,
  input  mem_pkg::word_t                     ram_rdata,
  input  logic [`NUM_STREAMS-1:0]            ready_downward,
  input  logic [`NUM_STREAMS-1:0]            val_in,
  input  mem_pkg::word_t [`NUM_STREAMS-1:0]  din,
  output logic                               mem_ready,
  output mem_pkg::word_t                     mem_rdata
);
  import mem_pkg::*;

  logic rd_from_rx;     // Return stream data instead of RAM
  port_idx_t rd_port;   // Stream port to return

  always_ff @(posedge clk) begin
    if (!resetn) begin
      mem_ready <= 1'b0;
      rd_from_rx <= 1'b0;
      rd_port <= '0;
    end else begin
      mem_ready <= 1'b0;  // Single-cycle pulse
      if (rsp.access) begin
        case (rsp.region)
          REG_TX:  mem_ready <= ready_downward[rsp.port];  // Wait for the sink
          REG_RX:  mem_ready <= val_in[rsp.port];          // Wait for the source
          default: mem_ready <= 1'b1;                      // RAM answers next cycle
        endcase
        rd_from_rx <= (rsp.region == REG_RX);
        rd_port <= rsp.port;
      end
    end
  end

  // Selector was set with the ready, so data lines up with it
  assign mem_rdata = rd_from_rx ? din[rd_port] : ram_rdata;

endmodule

//--- design/irq_timer.sv
`timescale 1ns/100ps

`include "mem_macros.svh"

module irq_timer (
  input  logic            clk,
  input  logic            resetn,
  output mem_pkg::word_t  irq
);

  logic [`IRQ_CNT_W-1:0] count_cycle;  // Free-running cycle count

  always_ff @(posedge clk) begin
    if (!resetn) begin
      count_cycle <= '0;
    end else begin
      count_cycle <= count_cycle + 1'b1;  // Wraps silently
    end
  end

  always_comb begin
    irq = '0;                                      // Unused lines stay quiet
    irq[4] = &count_cycle[`IRQ_FAST_BITS-1:0];     // Every 8192 cycles
    irq[5] = &count_cycle;                         // Every full wrap
  end

endmodule

//--- design/mem_decode.sv
`timescale 1ns/100ps

`include "mem_macros.svh"

module mem_decode (
  input  logic            clk,
  input  logic            resetn,
  input  logic            mem_valid,
  input  mem_pkg::word_t  mem_addr,
  input  mem_pkg::word_t  mem_wdata,
  input  mem_pkg::strb_t  mem_wstrb,
  input  logic            mem_ready,
  mem_dec_if.dec          dec
);
  import mem_pkg::*;

  mem_addr_u addr_view;  // Same address in RAM and MMIO form
  logic valid_q;         // mem_valid one cycle ago
  logic mmio_hit;        // Inside the stream register window
  logic [3:0] idx;       // Stream register index

  assign addr_view = mem_addr;
  assign idx = addr_view.mmio.reg_idx;

  // Only aligned words in the window are stream registers
  assign mmio_hit = (addr_view.mmio.base == `MMIO_BASE) && (addr_view.mmio.offset == 2'b00);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= mem_valid;  // History for edge detect
    end
  end

  always_comb begin
    dec.region = REG_RAM;  // Default falls through to RAM
    dec.port = '0;
    if (mmio_hit) begin
      if (idx[0] && (idx <= 4'd9)) begin
        dec.region = REG_RX;  // 1,3,5,7,9 -> ports 0..4
        dec.port = port_idx_t'(idx[3:1]);
      end else if (!idx[0] && (idx >= 4'd2) && (idx <= 4'd10)) begin
        dec.region = REG_TX;  // 2,4,6,8,10 -> ports 0..4
        dec.port = port_idx_t'(idx[3:1] - 3'd1);
      end
    end
  end

  // Shared qualifiers for the execute and result stages
  assign dec.access = mem_valid && !mem_ready;
  assign dec.first = mem_valid && !valid_q;  // Rising edge of valid

  // Payload passes through for the RAM
  assign dec.ram_index = addr_view.ram.index;
  assign dec.wstrb = mem_wstrb;
  assign dec.wdata = mem_wdata;

endmodule

//--- design/mem_top.sv
`timescale 1ns/100ps

`include "mem_macros.svh"

module mem_top (
  input  logic                               clk,
  input  logic                               resetn,

  // Core memory bus
  input  logic                               mem_valid,
  input  logic                               mem_instr,
  output logic                               mem_ready,
  input  mem_pkg::word_t                     mem_addr,
  input  mem_pkg::word_t                     mem_wdata,
  input  mem_pkg::strb_t                     mem_wstrb,
  output mem_pkg::word_t                     mem_rdata,

  // Stream outputs
  output logic [`NUM_STREAMS-1:0]            val_out,
  output mem_pkg::word_t [`NUM_STREAMS-1:0]  dout,
  input  logic [`NUM_STREAMS-1:0]            ready_downward,

  // Stream inputs
  input  mem_pkg::word_t [`NUM_STREAMS-1:0]  din,
  input  logic [`NUM_STREAMS-1:0]            val_in,
  output logic [`NUM_STREAMS-1:0]            ready_upward,

  // Timer interrupts
  output mem_pkg::word_t                     irq
);

  // mem_instr only tags fetches, data and instructions share the RAM

  mem_pkg::word_t ram_rdata;  // Registered RAM word

  mem_dec_if dec_bus ();

  mem_decode u_decode (
    .clk       (clk),
    .resetn    (resetn),
    .mem_valid (mem_valid),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .mem_ready (mem_ready),
    .dec       (dec_bus)
  );

  ram_bank u_ram (
    .clk   (clk),
    .ram   (dec_bus),
    .rdata (ram_rdata)
  );

  stream_ports u_streams (
    .clk          (clk),
    .resetn       (resetn),
    .strm         (dec_bus),
    .val_in       (val_in),
    .val_out      (val_out),
    .ready_upward (ready_upward)
  );

  bus_response u_response (
    .clk            (clk),
    .resetn         (resetn),
    .rsp            (dec_bus),
    .ram_rdata      (ram_rdata),
    .ready_downward (ready_downward),
    .val_in         (val_in),
    .din            (din),
    .mem_ready      (mem_ready),
    .mem_rdata      (mem_rdata)
  );

  irq_timer u_timer (
    .clk    (clk),
    .resetn (resetn),
    .irq    (irq)
  );

  // Every TX port sees the core write data, val_out marks the owner
  for (genvar k = 0; k < `NUM_STREAMS; k++) begin : g_dout
    assign dout[k] = mem_wdata;
  end

endmodule

//--- project.f
+incdir+common
common/mem_pkg.sv
common/mem_dec_if.sv
design/mem_decode.sv
ram/ram_bank.sv
stream/stream_ports.sv
design/bus_response.sv
design/irq_timer.sv
design/mem_top.sv
verif/tb_mem_top.sv

//--- ram/ram_bank.sv
`timescale 1ns/100ps

`include "mem_macros.svh"

module ram_bank (
  input  logic            clk,
  mem_dec_if.ram          ram,
  output mem_pkg::word_t  rdata
);
  import mem_pkg::*;

  localparam int LANE_W = `MEM_DATA_W / `MEM_LANES;  // Bits per byte lane
  localparam int RAM_DEPTH = 1 << `RAM_ADDR_BITS;    // Words per lane

  logic ram_hit;  // Live access aimed at RAM

  assign ram_hit = ram.access && (ram.region == REG_RAM);

  for (genvar l = 0; l < `MEM_LANES; l++) begin : g_lane
    logic [LANE_W-1:0] lane_mem [0:RAM_DEPTH-1];  // One byte column
    logic [LANE_W-1:0] lane_q;                    // Registered read byte

    always_ff @(posedge clk) begin
      if (ram_hit) begin
        if (ram.wstrb[l]) begin
          lane_mem[ram.ram_index] <= ram.wdata[l*LANE_W +: LANE_W];  // Strobed byte write
        end
        lane_q <= lane_mem[ram.ram_index];  // Old contents on a write
      end
    end

    assign rdata[l*LANE_W +: LANE_W] = lane_q;  // Holds between accesses
  end

endmodule

//--- stream/stream_ports.sv
`timescale 1ns/100ps

`include "mem_macros.svh"

module stream_ports (
  input  logic                    clk,
  input  logic                    resetn,
  mem_dec_if.strm                 strm,
  input  logic [`NUM_STREAMS-1:0] val_in,
  output logic [`NUM_STREAMS-1:0] val_out,
  output logic [`NUM_STREAMS-1:0] ready_upward
);
  import mem_pkg::*;

  for (genvar k = 0; k < `NUM_STREAMS; k++) begin : g_port
    logic port_sel;       // Decoded port matches k
    logic tx_first;       // First cycle of a TX write to k
    logic rx_first;       // First cycle of an RX read of k
    logic [7:0] rd_cnt;   // Reads issued by the core
    logic [7:0] acc_cnt;  // Words accepted upstream
    logic owe_ready;      // A read still needs its ready pulse
    logic upw_q;          // Registered upstream ready

    assign port_sel = (strm.port == port_idx_t'(k));
    assign tx_first = strm.first && (strm.region == REG_TX) && port_sel;
    assign rx_first = strm.first && (strm.region == REG_RX) && port_sel;

    // One-cycle valid pulse on the write, data comes straight from the bus
    assign val_out[k] = tx_first;

    assign owe_ready = (acc_cnt != rd_cnt) && val_in[k];

    always_ff @(posedge clk) begin
      if (!resetn) begin
        rd_cnt <= '0;
      end else if (rx_first) begin
        rd_cnt <= rd_cnt + 8'd1;  // Once per read, not per stall cycle
      end
    end

    always_ff @(posedge clk) begin
      if (!resetn) begin
        acc_cnt <= '0;
        upw_q <= 1'b0;
      end else begin
        upw_q <= owe_ready;  // Pulse while counts differ
        if (owe_ready) begin
          acc_cnt <= acc_cnt + 8'd1;  // Catch up one word
        end
      end
    end

    assign ready_upward[k] = upw_q;
  end

endmodule

//--- verif/tb_mem_top.sv
`timescale 1ns/100ps

`include "mem_macros.svh"

module tb_mem_top;
  import mem_pkg::*;

  localparam int CLK_PERIOD = 100;                  // ns
  localparam int MAX_ROWS = 64;                     // Table capacity
  localparam int IRQ_PERIOD = 1 << `IRQ_FAST_BITS;  // Fast irq spacing
  localparam int RAM_DEPTH = 1 << `RAM_ADDR_BITS;
  // Covers two fast irq periods plus every row at its longest stall
  localparam int TIMEOUT_CYCLES = 20000;

  typedef enum logic [1:0] {OP_RAM_WR, OP_RAM_RD, OP_TX, OP_RX} op_e;

  logic clk;
  logic resetn;
  logic mem_valid;
  logic mem_instr;
  logic mem_ready;
  word_t mem_addr;
  word_t mem_wdata;
  strb_t mem_wstrb;
  word_t mem_rdata;
  logic [`NUM_STREAMS-1:0] val_out;
  word_t [`NUM_STREAMS-1:0] dout;
  logic [`NUM_STREAMS-1:0] ready_downward;
  word_t [`NUM_STREAMS-1:0] din;
  logic [`NUM_STREAMS-1:0] val_in;
  logic [`NUM_STREAMS-1:0] ready_upward;
  word_t irq;

  // Stimulus table, one bus access per row
  string tbl_name [0:MAX_ROWS-1];
  op_e   tbl_op [0:MAX_ROWS-1];
  word_t tbl_addr [0:MAX_ROWS-1];
  word_t tbl_wdata [0:MAX_ROWS-1];      // Write data, or word offered on din for RX
  strb_t tbl_wstrb [0:MAX_ROWS-1];
  int    tbl_port [0:MAX_ROWS-1];
  int    tbl_rdy_delay [0:MAX_ROWS-1];  // Cycles ready_downward stays low
  int    tbl_val_delay [0:MAX_ROWS-1];  // Cycles val_in stays low
  word_t tbl_exp [0:MAX_ROWS-1];        // Expected read data
  int    num_rows = 0;

  word_t ram_model [0:RAM_DEPTH-1];  // Expected RAM contents, byte merged

  int tx_pulses [0:`NUM_STREAMS-1];   // Seen val_out pulses
  int exp_tx [0:`NUM_STREAMS-1];      // TX writes issued
  int upw_pulses [0:`NUM_STREAMS-1];  // Seen ready_upward pulses
  int rx_reads [0:`NUM_STREAMS-1];    // RX reads completed
  int irq4_pulses = 0;
  int irq_cycle = 0;                  // Cycles since reset release
  int cycle_count = 0;                // Whole run, for the timeout
  int seed_dummy;
  word_t exp_irq;

  mem_top UUT (
    .clk            (clk),
    .resetn         (resetn),
    .mem_valid      (mem_valid),
    .mem_instr      (mem_instr),
    .mem_ready      (mem_ready),
    .mem_addr       (mem_addr),
    .mem_wdata      (mem_wdata),
    .mem_wstrb      (mem_wstrb),
    .mem_rdata      (mem_rdata),
    .val_out        (val_out),
    .dout           (dout),
    .ready_downward (ready_downward),
    .din            (din),
    .val_in         (val_in),
    .ready_upward   (ready_upward),
    .irq            (irq)
  );

  always #(CLK_PERIOD/2) clk = ~clk;  // 100 ns period

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      fail_run($sformatf("MISMATCH %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      fail_run($sformatf("MISMATCH %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      fail_run($sformatf("MISMATCH %s: expected %0d, actual %0d", name, exp, act));
    end
  endtask

  task automatic add_row(input string name, input op_e op, input word_t addr,
                         input word_t wdata, input strb_t wstrb, input int port,
                         input int rdy_delay, input int val_delay, input word_t exp);
    tbl_name[num_rows] = name;
    tbl_op[num_rows] = op;
    tbl_addr[num_rows] = addr;
    tbl_wdata[num_rows] = wdata;
    tbl_wstrb[num_rows] = wstrb;
    tbl_port[num_rows] = port;
    tbl_rdy_delay[num_rows] = rdy_delay;
    tbl_val_delay[num_rows] = val_delay;
    tbl_exp[num_rows] = exp;
    num_rows++;
  endtask

  // Each set strobe bit replaces its byte lane
  task automatic model_write(input word_t addr, input word_t wdata, input strb_t wstrb);
    int idx;
    idx = addr[`RAM_ADDR_BITS+1:2];  // Word index, tag bits alias
    for (int l = 0; l < `MEM_LANES; l++) begin
      if (wstrb[l]) begin
        ram_model[idx][l*8 +: 8] = wdata[l*8 +: 8];
      end
    end
  endtask

  function automatic word_t model_read(input word_t addr);
    return ram_model[addr[`RAM_ADDR_BITS+1:2]];
  endfunction

  task automatic build_table();
    word_t base_addr [0:5];
    strb_t part_strb [0:5];
    word_t data;
    word_t alias_addr;
    part_strb = '{4'b0001, 4'b0110, 4'b1000, 4'b1010, 4'b0011, 4'b1100};
    for (int i = 0; i < 6; i++) begin
      base_addr[i] = $urandom & 32'h0fff_fffc;  // Top nibble clear keeps it off MMIO
      data = $urandom;
      add_row($sformatf("ram_full_wr_%0d", i), OP_RAM_WR, base_addr[i], data, 4'hf,
              0, 0, 0, '0);
      model_write(base_addr[i], data, 4'hf);
      add_row($sformatf("ram_full_rd_%0d", i), OP_RAM_RD, base_addr[i], '0, '0,
              0, 0, 0, model_read(base_addr[i]));
    end
    for (int i = 0; i < 6; i++) begin
      data = $urandom;
      alias_addr = base_addr[i] ^ 32'h0080_0000;  // Other tag aliases the same word
      add_row($sformatf("ram_part_wr_%0d", i), OP_RAM_WR, base_addr[i], data,
              part_strb[i], 0, 0, 0, '0);
      model_write(base_addr[i], data, part_strb[i]);
      add_row($sformatf("ram_part_rd_%0d", i), OP_RAM_RD, alias_addr, '0, '0,
              0, 0, 0, model_read(base_addr[i]));
    end
    for (int k = 0; k < `NUM_STREAMS; k++) begin
      add_row($sformatf("tx_port_%0d", k), OP_TX, word_t'(32'h1000_0008 + 8*k),
              $urandom, 4'hf, k, k, 0, '0);  // Stall grows with k
    end
    add_row("tx_port_1_long", OP_TX, 32'h1000_0010, $urandom, 4'hf, 1, 6, 0, '0);
    add_row("tx_port_4_long", OP_TX, 32'h1000_0028, $urandom, 4'hf, 4, 6, 0, '0);
    for (int k = 0; k < `NUM_STREAMS; k++) begin
      data = $urandom;
      add_row($sformatf("rx_port_%0d", k), OP_RX, word_t'(32'h1000_0004 + 8*k),
              data, '0, k, 0, k, data);
    end
    data = $urandom;
    add_row("rx_port_0_again", OP_RX, 32'h1000_0004, data, '0, 0, 0, 5, data);
    data = $urandom;
    add_row("rx_port_3_again", OP_RX, 32'h1000_001c, data, '0, 3, 0, 5, data);
    // Read source must fall back to RAM after stream reads
    add_row("ram_rd_after_rx", OP_RAM_RD, base_addr[0], '0, '0, 0, 0, 0,
            model_read(base_addr[0]));
  endtask

  // Runs one row from one falling edge to a later one
  task automatic apply_row(input int r);
    int k;
    int latency;
    int exp_latency;
    logic got;
    k = tbl_port[r];
    latency = 0;
    got = 1'b0;
    case (tbl_op[r])
      OP_TX:   exp_latency = tbl_rdy_delay[r] + 1;
      OP_RX:   exp_latency = tbl_val_delay[r] + 1;
      default: exp_latency = 1;  // RAM answers the cycle after valid
    endcase
    mem_valid = 1'b1;
    mem_addr = tbl_addr[r];
    mem_wstrb = tbl_wstrb[r];
    mem_wdata = (tbl_wstrb[r] != '0) ? tbl_wdata[r] : word_t'($urandom);
    for (int p = 0; p < `NUM_STREAMS; p++) begin
      din[p] = $urandom;  // Decoys on the other ports
    end
    if (tbl_op[r] == OP_RX) begin
      din[k] = tbl_wdata[r];
      val_in[k] = (tbl_val_delay[r] == 0);
    end
    if (tbl_op[r] == OP_TX) begin
      ready_downward[k] = (tbl_rdy_delay[r] == 0);
    end
    while (!got) begin
      @(negedge clk);
      latency++;
      got = mem_ready;
      if (!got && tbl_op[r] == OP_TX && latency == tbl_rdy_delay[r]) begin
        ready_downward[k] = 1'b1;  // Sink frees up
      end
      if (!got && tbl_op[r] == OP_RX && latency == tbl_val_delay[r]) begin
        val_in[k] = 1'b1;  // Source has data
      end
    end
    check_count({tbl_name[r], "_latency"}, exp_latency, latency);
    case (tbl_op[r])
      OP_RAM_RD: check_word(tbl_name[r], tbl_exp[r], mem_rdata);
      OP_RX: begin
        check_word(tbl_name[r], tbl_exp[r], mem_rdata);
        rx_reads[k]++;
      end
      OP_TX: begin
        check_word({tbl_name[r], "_dout"}, tbl_wdata[r], dout[k]);
        exp_tx[k]++;
      end
      default: ;
    endcase
    @(negedge clk);  // Core still holds the request across the ready edge
    check_bit({tbl_name[r], "_ready_drop"}, 1'b0, mem_ready);  // Never two in a row
    mem_valid = 1'b0;
    mem_wstrb = '0;
    ready_downward = '0;
    val_in = '0;
    @(negedge clk);  // Idle cycle so the next valid is a new rising edge
    for (int p = 0; p < `NUM_STREAMS; p++) begin
      check_count($sformatf("%s_val_out_%0d", tbl_name[r], p), exp_tx[p], tx_pulses[p]);
    end
  endtask

  // Pulse counters and irq model sampled at the rising edge
  always @(posedge clk) begin
    if (resetn) begin
      for (int p = 0; p < `NUM_STREAMS; p++) begin
        if (val_out[p]) tx_pulses[p]++;
        if (ready_upward[p]) upw_pulses[p]++;
      end
      exp_irq = '0;
      exp_irq[4] = (irq_cycle % IRQ_PERIOD) == (IRQ_PERIOD - 1);
      exp_irq[5] = (irq_cycle % 65536) == 65535;
      check_word($sformatf("irq_cycle_%0d", irq_cycle), exp_irq, irq);
      if (irq[4]) irq4_pulses++;
      irq_cycle++;
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      fail_run($sformatf("Timeout after %0d cycles, mem_ready never arrived", cycle_count));
    end
  end

  initial begin
    seed_dummy = $urandom(32'h9a9f);  // Fixed seed for the run
    clk = 1'b0;
    resetn = 1'b0;
    mem_valid = 1'b0;
    mem_instr = 1'b0;
    mem_addr = '0;
    mem_wdata = '0;
    mem_wstrb = '0;
    ready_downward = '0;
    din = '0;
    val_in = '0;
    for (int p = 0; p < `NUM_STREAMS; p++) begin
      tx_pulses[p] = 0;
      exp_tx[p] = 0;
      upw_pulses[p] = 0;
      rx_reads[p] = 0;
    end
    build_table();
    repeat (3) @(negedge clk);  // Three reset cycles
    resetn = 1'b1;
    @(negedge clk);
    check_bit("reset_mem_ready", 1'b0, mem_ready);
    check_count("reset_ready_upward", 0, int'(ready_upward));
    for (int r = 0; r < num_rows; r++) begin
      apply_row(r);
    end
    val_in = '1;  // Lets owed upstream pulses drain
    while (irq_cycle < 2 * IRQ_PERIOD + 8) begin
      @(negedge clk);
    end
    for (int p = 0; p < `NUM_STREAMS; p++) begin
      check_count($sformatf("ready_upward_%0d", p), rx_reads[p], upw_pulses[p]);
    end
    check_count("irq4_pulses", 2, irq4_pulses);
    $display("Simulation PASSED");
    $finish;
  end

endmodule
